//--- verilog/mfq_pkg.sv
// shared types and constants for the byte queue
// lane count, byte and lane vectors, apb offsets
package mfq_pkg;

  localparam int lanes = 4;  // byte lanes per 32-bit apb word

  typedef logic [7:0]        byte_t;
  typedef logic [lanes-1:0]  lane_mask_t;  // one bit per lane
  typedef byte_t [lanes-1:0] lane_data_t;  // lane 0 in bits 7:0
  typedef logic [2:0]        lane_cnt_t;   // 0 to lanes
  typedef logic [11:0]       apb_addr_t;

  // apb register offsets shared by every port
  localparam apb_addr_t addr_data = 12'h000;  // push or pop data
  localparam apb_addr_t addr_ctrl = 12'h004;  // count read, clear write

endpackage

//--- verilog/mfq_push_if.sv
// request bundle between a producer port and the push arbiter
// producer and arbiter modports
`timescale 1ns/100ps

interface mfq_push_if;
  import mfq_pkg::*;

  logic       req;    // held until granted
  lane_cnt_t  cnt;    // lanes requested
  lane_mask_t push;   // contiguous from lane 0
  lane_data_t data;   // compacted bytes
  logic       grant;  // combinational from arbiter

  modport producer (
    output req,
    output cnt,
    output push,
    output data,
    input  grant
  );

  modport arbiter (
    input  req,
    input  cnt,
    input  push,
    input  data,
    output grant
  );

endinterface

//--- verilog/multi_fifo.sv
// synchronous byte fifo with multi-lane push and pop
// head lanes read combinationally from rptr
// per-lane almost full / almost empty vectors
// pointers and entry count exported
`timescale 1ns/100ps

module multi_fifo #(
  parameter int DEPTH = 16  // power of two, at least lanes
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mfq_pkg::lane_mask_t       push,
  input  mfq_pkg::lane_data_t       datain,
  input  mfq_pkg::lane_mask_t       pop,
  input  logic                      clear,
  output mfq_pkg::lane_data_t       dataout,
  output logic                      full,
  output mfq_pkg::lane_mask_t       almost_full,
  output logic                      empty,
  output mfq_pkg::lane_mask_t       almost_empty,
  output logic [$clog2(DEPTH)-1:0]  wptr,
  output logic [$clog2(DEPTH)-1:0]  rptr,
  output logic [$clog2(DEPTH):0]    entry_count
);
  import mfq_pkg::*;

  localparam int ptr_w = $clog2(DEPTH);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0]   count_t;

  byte_t     mem [DEPTH];
  ptr_t      wr_addr [lanes];
  ptr_t      rd_addr [lanes];
  lane_cnt_t push_cnt;
  lane_cnt_t pop_cnt;
  count_t    free_cnt;

  assign free_cnt = count_t'(DEPTH) - entry_count;
  assign full     = (entry_count == count_t'(DEPTH));
  assign empty    = (entry_count == '0);

  // lane addresses wrap with the pointer width
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign wr_addr[i]      = wptr + ptr_t'(i);
    assign rd_addr[i]      = rptr + ptr_t'(i);
    assign dataout[i]      = mem[rd_addr[i]];
    assign almost_full[i]  = (free_cnt <= count_t'(i));     // free space <= i
    assign almost_empty[i] = (entry_count <= count_t'(i));  // fill level <= i
  end

  // popcount of both masks
  always_comb begin
    push_cnt = '0;
    pop_cnt  = '0;
    for (int i = 0; i < lanes; i++) begin
      push_cnt = push_cnt + lane_cnt_t'(push[i]);
      pop_cnt  = pop_cnt + lane_cnt_t'(pop[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr        <= '0;
      rptr        <= '0;
      entry_count <= '0;
    end else if (clear) begin
      wptr        <= '0;  // clear beats push and pop
      rptr        <= '0;
      entry_count <= '0;
    end else begin
      wptr        <= wptr + ptr_t'(push_cnt);
      rptr        <= rptr + ptr_t'(pop_cnt);
      entry_count <= entry_count + count_t'(push_cnt) - count_t'(pop_cnt);
    end
  end

  // lane i lands at wptr + i
  always_ff @(posedge clk) begin
    for (int i = 0; i < lanes; i++) begin
      if (push[i]) begin
        mem[wr_addr[i]] <= datain[i];
      end
    end
  end

endmodule

//--- verilog/apb_push_port.sv
// apb slave for one producer
// packs strobed bytes toward lane 0 in the setup phase
// requests a multi-push and waits in access until granted
// reads return the queue entry count
`timescale 1ns/100ps

module apb_push_port #(
  parameter int DEPTH = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  mfq_pkg::apb_addr_t      paddr,
  input  mfq_pkg::lane_data_t     pwdata,
  input  mfq_pkg::lane_mask_t     pstrb,
  input  logic [$clog2(DEPTH):0]  entry_count,
  output mfq_pkg::lane_data_t     prdata,
  output logic                    pready,
  output logic                    pslverr,
  mfq_push_if.producer            push_if
);
  import mfq_pkg::*;

  lane_data_t pack_data;
  lane_cnt_t  pack_cnt;
  lane_data_t data_q;
  lane_cnt_t  cnt_q;      // zero when the transfer pushes nothing
  lane_mask_t push_mask;
  logic       setup;
  logic       access;

  assign setup  = psel & ~penable;
  assign access = psel & penable;

  // compaction in ascending lane order
  always_comb begin
    pack_data = '0;
    pack_cnt  = '0;
    for (int i = 0; i < lanes; i++) begin
      if (pstrb[i]) begin
        pack_data[pack_cnt[1:0]] = pwdata[i];
        pack_cnt = pack_cnt + lane_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (setup) begin
      cnt_q <= (pwrite && paddr == addr_data) ? pack_cnt : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (setup) begin
      data_q <= pack_data;
    end
  end

  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      push_mask[i] = (lane_cnt_t'(i) < cnt_q);
    end
  end

  assign push_if.req  = access & (cnt_q != '0);
  assign push_if.cnt  = cnt_q;
  assign push_if.push = push_mask;
  assign push_if.data = data_q;

  // empty-strobe writes and reads finish in the first access cycle
  assign pready  = access & ((cnt_q == '0) | push_if.grant);
  assign prdata  = (access & ~pwrite) ? lane_data_t'(entry_count) : '0;
  assign pslverr = 1'b0;

endmodule

//--- verilog/push_arbiter.sv
// round-robin arbiter between the two producer ports
// grants only when the whole request fits in the free space
// drives the fifo push mask and data from the granted port
`timescale 1ns/100ps

module push_arbiter #(
  parameter int DEPTH = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [$clog2(DEPTH):0]  entry_count,
  mfq_push_if.arbiter             port0,
  mfq_push_if.arbiter             port1,
  output mfq_pkg::lane_mask_t     push,
  output mfq_pkg::lane_data_t     datain
);
  import mfq_pkg::*;

  localparam int cnt_w = $clog2(DEPTH) + 1;

  typedef logic [cnt_w-1:0] count_t;

  count_t free_cnt;
  logic   prio_q;  // set when port 1 goes first
  logic   pick1;
  logic   fits;

  assign free_cnt = count_t'(DEPTH) - entry_count;

  // winner picked on req alone so a large write is never overtaken
  assign pick1 = port1.req & (prio_q | ~port0.req);
  assign fits  = pick1 ? (count_t'(port1.cnt) <= free_cnt)
                       : (count_t'(port0.cnt) <= free_cnt);

  assign port0.grant = port0.req & ~pick1 & fits;
  assign port1.grant = pick1 & fits;

  assign push   = port0.grant ? port0.push : (port1.grant ? port1.push : '0);
  assign datain = port0.grant ? port0.data : (port1.grant ? port1.data : '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_q <= 1'b0;
    end else if (port0.grant) begin
      prio_q <= 1'b1;  // other port next time
    end else if (port1.grant) begin
      prio_q <= 1'b0;
    end
  end

endmodule

//--- verilog/apb_pop_port.sv
// apb slave for the consumer
// data read pops up to four head bytes, empty lanes read as zero
// control read returns the entry count, control write clears
`timescale 1ns/100ps

module apb_pop_port #(
  parameter int DEPTH = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  mfq_pkg::apb_addr_t      paddr,
  input  mfq_pkg::lane_data_t     dataout,
  input  mfq_pkg::lane_mask_t     almost_empty,
  input  logic [$clog2(DEPTH):0]  entry_count,
  output mfq_pkg::lane_data_t     prdata,
  output logic                    pready,
  output logic                    pslverr,
  output mfq_pkg::lane_mask_t     pop,
  output logic                    clear
);
  import mfq_pkg::*;

  logic       access;
  logic       rd_data_q;  // decoded in setup phase
  logic       rd_ctrl_q;
  logic       wr_ctrl_q;
  lane_mask_t valid;

  assign access = psel & penable;
  assign valid  = ~almost_empty;  // lane i holds data when count > i

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_q <= 1'b0;
      rd_ctrl_q <= 1'b0;
      wr_ctrl_q <= 1'b0;
    end else if (psel & ~penable) begin
      rd_data_q <= ~pwrite & (paddr == addr_data);
      rd_ctrl_q <= ~pwrite & (paddr == addr_ctrl);
      wr_ctrl_q <= pwrite & (paddr == addr_ctrl);
    end
  end

  assign pop     = (access & rd_data_q) ? valid : '0;
  assign clear   = access & wr_ctrl_q;
  assign pready  = access;  // single access cycle always
  assign pslverr = 1'b0;

  always_comb begin
    prdata = '0;
    if (access & rd_data_q) begin
      for (int i = 0; i < lanes; i++) begin
        prdata[i] = valid[i] ? dataout[i] : '0;
      end
    end else if (access & rd_ctrl_q) begin
      prdata = lane_data_t'(entry_count);
    end
  end

endmodule

//--- verilog/mfq_top.sv
// shared byte queue top level
// two producer apb slaves and one consumer apb slave
// producers reach the fifo through the round-robin push arbiter
`timescale 1ns/100ps

module mfq_top #(
  parameter int DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // producer 0
  input  logic                 p0_psel,
  input  logic                 p0_penable,
  input  logic                 p0_pwrite,
  input  mfq_pkg::apb_addr_t   p0_paddr,
  input  mfq_pkg::lane_data_t  p0_pwdata,
  input  mfq_pkg::lane_mask_t  p0_pstrb,
  output mfq_pkg::lane_data_t  p0_prdata,
  output logic                 p0_pready,
  output logic                 p0_pslverr,
  // producer 1
  input  logic                 p1_psel,
  input  logic                 p1_penable,
  input  logic                 p1_pwrite,
  input  mfq_pkg::apb_addr_t   p1_paddr,
  input  mfq_pkg::lane_data_t  p1_pwdata,
  input  mfq_pkg::lane_mask_t  p1_pstrb,
  output mfq_pkg::lane_data_t  p1_prdata,
  output logic                 p1_pready,
  output logic                 p1_pslverr,
  // consumer
  input  logic                 c_psel,
  input  logic                 c_penable,
  input  logic                 c_pwrite,
  input  mfq_pkg::apb_addr_t   c_paddr,
  output mfq_pkg::lane_data_t  c_prdata,
  output logic                 c_pready,
  output logic                 c_pslverr
);
  import mfq_pkg::*;

  localparam int cnt_w = $clog2(DEPTH) + 1;

  logic [cnt_w-1:0] entry_count;
  lane_mask_t       push;
  lane_data_t       datain;
  lane_mask_t       pop;
  logic             clear;
  lane_data_t       dataout;
  lane_mask_t       almost_empty;

  mfq_push_if p0_if ();
  mfq_push_if p1_if ();

  apb_push_port #(.DEPTH(DEPTH)) u_p0_port (
    .clk(clk), .rst_n(rst_n),
    .psel(p0_psel), .penable(p0_penable), .pwrite(p0_pwrite), .paddr(p0_paddr),
    .pwdata(p0_pwdata), .pstrb(p0_pstrb), .entry_count(entry_count),
    .prdata(p0_prdata), .pready(p0_pready), .pslverr(p0_pslverr),
    .push_if(p0_if.producer)
  );

  apb_push_port #(.DEPTH(DEPTH)) u_p1_port (
    .clk(clk), .rst_n(rst_n),
    .psel(p1_psel), .penable(p1_penable), .pwrite(p1_pwrite), .paddr(p1_paddr),
    .pwdata(p1_pwdata), .pstrb(p1_pstrb), .entry_count(entry_count),
    .prdata(p1_prdata), .pready(p1_pready), .pslverr(p1_pslverr),
    .push_if(p1_if.producer)
  );

  push_arbiter #(.DEPTH(DEPTH)) u_arbiter (
    .clk(clk), .rst_n(rst_n), .entry_count(entry_count),
    .port0(p0_if.arbiter), .port1(p1_if.arbiter),
    .push(push), .datain(datain)
  );

  // the shared byte queue
  multi_fifo #(.DEPTH(DEPTH)) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(push), .datain(datain), .pop(pop), .clear(clear),
    .dataout(dataout), .full(), .almost_full(), .empty(),
    .almost_empty(almost_empty), .wptr(), .rptr(), .entry_count(entry_count)
  );

  apb_pop_port #(.DEPTH(DEPTH)) u_pop_port (
    .clk(clk), .rst_n(rst_n),
    .psel(c_psel), .penable(c_penable), .pwrite(c_pwrite), .paddr(c_paddr),
    .dataout(dataout), .almost_empty(almost_empty), .entry_count(entry_count),
    .prdata(c_prdata), .pready(c_pready), .pslverr(c_pslverr),
    .pop(pop), .clear(clear)
  );

endmodule

//--- testbench/tb_mfq.sv
// testbench for the shared byte queue
// clock and reset, apb driver tasks for the two producer ports and the consumer
// operations and expected values come from the vector file
`timescale 1ns/100ps

module tb_mfq;
  import mfq_pkg::*;

  localparam int depth      = 16;
  localparam int wait_limit = 50;  // cycles per handshake

  typedef logic [$clog2(depth):0] count_t;

  logic       clk;
  logic       rst_n;
  logic       p0_psel;
  logic       p0_penable;
  logic       p0_pwrite;
  apb_addr_t  p0_paddr;
  lane_data_t p0_pwdata;
  lane_mask_t p0_pstrb;
  lane_data_t p0_prdata;
  logic       p0_pready;
  logic       p0_pslverr;
  logic       p1_psel;
  logic       p1_penable;
  logic       p1_pwrite;
  apb_addr_t  p1_paddr;
  lane_data_t p1_pwdata;
  lane_mask_t p1_pstrb;
  lane_data_t p1_prdata;
  logic       p1_pready;
  logic       p1_pslverr;
  logic       c_psel;
  logic       c_penable;
  logic       c_pwrite;
  apb_addr_t  c_paddr;
  lane_data_t c_prdata;
  logic       c_pready;
  logic       c_pslverr;
  logic       write_done;  // set once the held write completes

  mfq_top #(.DEPTH(depth)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_data(input lane_data_t got, input lane_data_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic set_producer(input int port, input logic sel, input logic en, input logic wr,
                              input apb_addr_t addr, input lane_data_t wdata,
                              input lane_mask_t strb);
    if (port == 0) begin
      p0_psel    = sel;
      p0_penable = en;
      p0_pwrite  = wr;
      p0_paddr   = addr;
      p0_pwdata  = wdata;
      p0_pstrb   = strb;
    end else begin
      p1_psel    = sel;
      p1_penable = en;
      p1_pwrite  = wr;
      p1_paddr   = addr;
      p1_pwdata  = wdata;
      p1_pstrb   = strb;
    end
  endtask

  function automatic logic producer_ready(input int port);
    return (port == 0) ? p0_pready : p1_pready;
  endfunction

  // setup, access until pready, then idle; outputs sampled mid-cycle
  task automatic producer_access(input int port, input logic wr, input apb_addr_t addr,
                                 input lane_data_t wdata, input lane_mask_t strb,
                                 output lane_data_t rdata);
    int waited = 0;
    @(negedge clk);
    set_producer(port, 1'b1, 1'b0, wr, addr, wdata, strb);
    @(negedge clk);
    set_producer(port, 1'b1, 1'b1, wr, addr, wdata, strb);
    #2;
    while (!producer_ready(port)) begin
      if (waited == wait_limit) begin
        fail_run($sformatf("producer %0d transfer never became ready", port));
      end
      @(negedge clk);
      #2;
      waited++;
    end
    rdata = (port == 0) ? p0_prdata : p1_prdata;
    check_flag((port == 0) ? p0_pslverr : p1_pslverr, 1'b0, "producer pslverr");
    @(negedge clk);
    set_producer(port, 1'b0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic consumer_access(input logic wr, input apb_addr_t addr,
                                 output lane_data_t rdata);
    int waited = 0;
    @(negedge clk);
    c_psel    = 1'b1;
    c_penable = 1'b0;
    c_pwrite  = wr;
    c_paddr   = addr;
    @(negedge clk);
    c_penable = 1'b1;
    #2;
    while (!c_pready) begin
      if (waited == wait_limit) begin
        fail_run("consumer transfer never became ready");
      end
      @(negedge clk);
      #2;
      waited++;
    end
    rdata = c_prdata;
    check_flag(c_pslverr, 1'b0, "consumer pslverr");
    @(negedge clk);
    c_psel    = 1'b0;
    c_penable = 1'b0;
  endtask

  // write into a full queue that only a pop lets through
  task automatic held_write(input int port, input lane_mask_t strb, input lane_data_t wdata,
                            input lane_data_t pop_exp);
    lane_data_t wr_rd;
    lane_data_t pop_rd;
    write_done = 1'b0;
    fork
      begin
        producer_access(port, 1'b1, addr_data, wdata, strb, wr_rd);
        write_done = 1'b1;
      end
      begin
        repeat (4) @(negedge clk);
        if (write_done) begin
          fail_run("write into a full queue completed before any pop");
        end
        consumer_access(1'b0, addr_data, pop_rd);
        check_data(pop_rd, pop_exp, "pop during held write");
      end
    join
  endtask

  task automatic run_vector(input logic [7:0] op, input int port, input logic [31:0] field,
                            input logic [31:0] wdata, input logic [31:0] expected);
    lane_data_t rd;
    lane_data_t rd_other;
    case (op)
      "W": producer_access(port, 1'b1, addr_data, wdata, lane_mask_t'(field), rd);
      "R": begin
        producer_access(port, 1'b0, addr_ctrl, '0, '0, rd);
        check_count(count_t'(rd), count_t'(expected), "producer count read");
      end
      "P": begin
        consumer_access(1'b0, addr_data, rd);
        check_data(rd, expected, "pop data");
      end
      "K": begin
        consumer_access(1'b0, addr_ctrl, rd);
        check_count(count_t'(rd), count_t'(expected), "consumer count read");
      end
      "C": consumer_access(1'b1, addr_ctrl, rd);
      "D": begin
        fork  // both ports start on the same cycle
          producer_access(0, 1'b1, addr_data, wdata, lane_mask_t'(field), rd);
          producer_access(1, 1'b1, addr_data, expected, lane_mask_t'(field), rd_other);
        join
      end
      "B": held_write(port, lane_mask_t'(field), wdata, expected);
      default: fail_run($sformatf("unknown operation code %c in vector file", op));
    endcase
  endtask

  initial begin
    string       line;
    int          fd;
    int          ops_run = 0;
    int          port;
    logic [7:0]  op;
    logic [31:0] field;
    logic [31:0] wdata;
    logic [31:0] expected;
    rst_n      = 1'b0;
    write_done = 1'b0;
    set_producer(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    set_producer(1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    c_psel     = 1'b0;
    c_penable  = 1'b0;
    c_pwrite   = 1'b0;
    c_paddr    = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (p0_pready | p1_pready | c_pready) begin
      fail_run("pready was high right after reset");
    end
    fd = $fopen("testbench/mfq_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("could not open testbench/mfq_vectors.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%c %d %h %h %h", op, port, field, wdata, expected) != 5) begin
          fail_run($sformatf("malformed vector line: %s", line));
        end
        run_vector(op, port, field, wdata, expected);
        ops_run++;
      end
    end
    $fclose(fd);
    if (ops_run > 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("vector file held no operations");
    end
  end

endmodule

//--- testbench/mfq_vectors.txt
# op port strb_or_field wdata expected (hex, D: wdata port 0, expected port 1 data)
# ops: W write, R producer count, P pop, K consumer count, C clear, D dual, B held write
D 0 f 13121110 23222120
K 0 0 0 8
P 0 0 0 13121110
P 0 0 0 23222120
K 0 0 0 0
W 0 f ddccbbaa 0
K 0 0 0 4
R 1 0 0 4
P 0 0 0 ddccbbaa
K 0 0 0 0
# port 0 granted last, so port 1 goes first
D 0 f 33323130 43424140
P 0 0 0 43424140
P 0 0 0 33323130
W 1 a 44332211 0
K 0 0 0 2
P 0 0 0 00004422
K 0 0 0 0
W 0 0 ffffffff 0
K 0 0 0 0
W 0 7 ff665544 0
P 0 0 0 00665544
K 0 0 0 0
W 1 8 99000000 0
R 0 0 0 1
P 0 0 0 00000099
P 0 0 0 00000000
K 0 0 0 0
# fill to 16 bytes, then a write that must wait for a pop
W 0 f 03020100 0
W 1 f 07060504 0
W 0 f 0b0a0908 0
W 1 f 0f0e0d0c 0
K 0 0 0 10
B 0 f 13121110 03020100
P 0 0 0 07060504
P 0 0 0 0b0a0908
P 0 0 0 0f0e0d0c
P 0 0 0 13121110
K 0 0 0 0
W 0 f 87868584 0
W 1 3 00009291 0
K 0 0 0 6
C 0 0 0 0
K 0 0 0 0
W 1 f c3c2c1c0 0
P 0 0 0 c3c2c1c0
K 0 0 0 0

//--- tb.f
verilog/mfq_pkg.sv
verilog/mfq_push_if.sv
verilog/multi_fifo.sv
verilog/apb_push_port.sv
verilog/push_arbiter.sv
verilog/apb_pop_port.sv
verilog/mfq_top.sv
testbench/tb_mfq.sv

//--- Makefile
# verilator build and run of the byte queue testbench
TOP := tb_mfq

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f tb.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
